// ==== hdl/coeff_regs.sv ====
`timescale 1ns/10ps

module coeff_regs
	import fir_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        we,
	input  coeff_addr_t waddr,
	input  coeff_t      wdata,
	input  coeff_addr_t raddr,
	output coeff_t      rdata,
	input  coeff_addr_t tap_addr,
	output coeff_t      tap_coeff
);

	localparam coeff_addr_t LAST_ADDR = coeff_addr_t'(HALF_TAPS - 1);

	coeff_t regs [HALF_TAPS];
	logic   waddr_ok;
	logic   raddr_ok;
	logic   tap_ok;

	assign waddr_ok = (waddr <= LAST_ADDR);
	assign raddr_ok = (raddr <= LAST_ADDR);
	assign tap_ok   = (tap_addr <= LAST_ADDR);

	// Table comes back to the low-pass default on every reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= DEFAULT_COEFFS;
		end else if (we && waddr_ok) begin
			regs[waddr] <= wdata; // Lands on the next edge.
		end
	end

	// Host readback port.
	always_comb begin
		rdata = '0;
		if (raddr_ok) begin
			rdata = regs[raddr];
		end
	end

	// Tap port for the core, read every cycle of a computation.
	always_comb begin
		tap_coeff = '0;
		if (tap_ok) begin
			tap_coeff = regs[tap_addr];
		end
	end

	a_write_in_range: assert property (
		@(posedge clk) disable iff (rst) we |-> waddr_ok
	) else $error("coeff_regs: write to address %0d beyond the table", waddr);

endmodule

// ==== hdl/fir_core.sv ====
`timescale 1ns/10ps

module fir_core
	import fir_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        sample,
	input  sample_t     left_in,
	input  sample_t     right_in,
	output coeff_addr_t tap_addr,
	input  coeff_t      tap_coeff,
	output logic        hist_we,
	output hist_addr_t  left_addr,
	output hist_addr_t  right_addr,
	output sample_t     left_wdata,
	output sample_t     right_wdata,
	input  sample_t     left_rdata,
	input  sample_t     right_rdata,
	output acc_t        left_out,
	output acc_t        right_out,
	output logic        sample_out
);

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_LEFT  = 2'd1,
		ST_RIGHT = 2'd2
	} state_t;

	localparam coeff_addr_t CENTRE_TAP = coeff_addr_t'(HALF_TAPS - 1);

	state_t      state;
	logic        last_sample;
	logic        update;     // One cycle after the sample edge.
	logic        start;
	logic        done;       // Last MAC finished and outputs load next edge.
	sample_t     left_hold;
	sample_t     right_hold;
	sample_t     buf_left;
	sample_t     buf_right;
	hist_addr_t  wr_ptr;
	hist_addr_t  fwd_ptr;
	hist_addr_t  rev_ptr;
	coeff_addr_t cnt;
	logic        last_tap;
	logic signed [DATA_W:0]  op_a;
	logic signed [DATA_W:0]  op_b;
	logic signed [DATA_W:0]  pair_sum;
	logic signed [MAC_W-1:0] mac;
	acc_t        acc_left;
	acc_t        acc_right;

	// Sample edge detect.
	always_ff @(posedge clk) begin
		if (rst) begin
			last_sample <= 1'b0;
			update      <= 1'b0;
		end else begin
			last_sample <= sample;
			update      <= sample & ~last_sample;
		end
	end

	// Inputs as seen on the edge where sample went high.
	always_ff @(posedge clk) begin
		left_hold  <= left_in;
		right_hold <= right_in;
	end

	assign start       = update && (state == ST_IDLE) && !done; // Busy strobes drop here.
	assign hist_we     = start;
	assign left_wdata  = left_hold;
	assign right_wdata = right_hold;
	assign tap_addr    = cnt;
	assign last_tap    = (cnt == CENTRE_TAP);

	// Each memory gives one operand per cycle; the partner sits in the buffer.
	always_comb begin
		case (state)
			ST_LEFT: begin
				left_addr  = rev_ptr;
				right_addr = fwd_ptr;
			end
			ST_RIGHT: begin
				left_addr  = fwd_ptr;
				right_addr = rev_ptr;
			end
			default: begin
				left_addr  = wr_ptr;
				right_addr = wr_ptr;
			end
		endcase
	end

	// Pre-adder. The centre tap has no partner.
	always_comb begin
		if (state == ST_LEFT) begin
			op_a = {buf_left[DATA_W-1], buf_left};
			op_b = {left_rdata[DATA_W-1], left_rdata};
		end else begin
			op_a = {buf_right[DATA_W-1], buf_right};
			op_b = {right_rdata[DATA_W-1], right_rdata};
		end
		pair_sum = last_tap ? op_a : op_a + op_b;
	end

	assign mac = MAC_W'(tap_coeff) * MAC_W'(pair_sum); // The single multiplier.

	// Control and outputs.
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ST_IDLE;
			done       <= 1'b0;
			sample_out <= 1'b0;
			wr_ptr     <= '0;
			fwd_ptr    <= '0;
			rev_ptr    <= '0;
			cnt        <= '0;
			left_out   <= '0;
			right_out  <= '0;
		end else begin
			sample_out <= done;
			done       <= 1'b0;
			if (done) begin
				left_out  <= acc_left;
				right_out <= acc_right;
				wr_ptr    <= wr_ptr - 1'b1; // Newest sample sits at the lowest address.
			end
			case (state)
				ST_IDLE: begin
					if (start) begin
						cnt     <= '0;
						fwd_ptr <= wr_ptr;
						rev_ptr <= wr_ptr + hist_addr_t'(TAPS - 1);
						state   <= ST_LEFT;
					end
				end
				ST_LEFT: begin
					fwd_ptr <= fwd_ptr + 1'b1;
					state   <= ST_RIGHT;
				end
				ST_RIGHT: begin
					if (last_tap) begin
						done  <= 1'b1;
						state <= ST_IDLE;
					end else begin
						cnt     <= cnt + 1'b1;
						rev_ptr <= rev_ptr - 1'b1;
						state   <= ST_LEFT;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Accumulators and operand buffers.
	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				if (start) begin
					acc_left  <= '0;
					acc_right <= '0;
					buf_left  <= left_hold; // Newest left sample x[0].
				end
			end
			ST_LEFT: begin
				acc_left  <= acc_left + acc_t'(mac);
				buf_right <= right_rdata;
			end
			ST_RIGHT: begin
				acc_right <= acc_right + acc_t'(mac);
				buf_left  <= left_rdata;
			end
			default: ;
		endcase
	end

	a_done_single: assert property (
		@(posedge clk) disable iff (rst) sample_out |=> !sample_out
	) else $error("fir_core: sample_out high on two cycles in a row");

endmodule

// ==== hdl/fir_pkg.sv ====
package fir_pkg;

	// Datapath widths.
	localparam int DATA_W       = 9;
	localparam int COEFF_W      = 9;
	localparam int TAPS         = 73;
	localparam int HALF_TAPS    = (TAPS + 1) / 2;   // Unique coefficients.
	localparam int HIST_ADDR_W  = 7;                // 128 words of history.
	localparam int COEFF_ADDR_W = 6;
	localparam int MAC_W        = DATA_W + COEFF_W + 1;
	localparam int ACC_W        = MAC_W + 3;

	typedef logic signed [DATA_W-1:0]     sample_t;
	typedef logic signed [COEFF_W-1:0]    coeff_t;
	typedef logic signed [ACC_W-1:0]      acc_t;
	typedef logic        [HIST_ADDR_W-1:0]  hist_addr_t;
	typedef logic        [COEFF_ADDR_W-1:0] coeff_addr_t;

	// Low-pass table, outermost tap first, centre tap last.
	localparam coeff_t DEFAULT_COEFFS [HALF_TAPS] = '{
		9'sd0,   -9'sd1,  -9'sd1,  -9'sd2,  -9'sd3,  -9'sd3,
		-9'sd4,  -9'sd4,  -9'sd3,  -9'sd1,  9'sd1,   9'sd3,
		9'sd7,   9'sd10,  9'sd12,  9'sd13,  9'sd12,  9'sd9,
		9'sd3,   -9'sd5,  -9'sd14, -9'sd24, -9'sd33, -9'sd40,
		-9'sd43, -9'sd39, -9'sd29, -9'sd12, 9'sd13,  9'sd44,
		9'sd80,  9'sd119, 9'sd157, 9'sd192, 9'sd222, 9'sd243,
		9'sd255
	};

endpackage

// ==== hdl/fir_top.sv ====
`timescale 1ns/10ps

module fir_top
	import fir_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        sample,
	input  sample_t     left_in,
	input  sample_t     right_in,
	input  logic        coeff_we,
	input  coeff_addr_t coeff_waddr,
	input  coeff_t      coeff_wdata,
	input  coeff_addr_t coeff_raddr,
	output coeff_t      coeff_rdata,
	output acc_t        left_out,
	output acc_t        right_out,
	output logic        sample_out
);

	coeff_addr_t tap_addr;
	coeff_t      tap_coeff;
	logic        hist_we;
	hist_addr_t  left_addr;
	hist_addr_t  right_addr;
	sample_t     left_wdata;
	sample_t     right_wdata;
	sample_t     left_rdata;
	sample_t     right_rdata;

	coeff_regs i_coeff_regs (
		.clk       (clk),
		.rst       (rst),
		.we        (coeff_we),
		.waddr     (coeff_waddr),
		.wdata     (coeff_wdata),
		.raddr     (coeff_raddr),
		.rdata     (coeff_rdata),
		.tap_addr  (tap_addr),
		.tap_coeff (tap_coeff)
	);

	fir_core i_fir_core (
		.clk         (clk),
		.rst         (rst),
		.sample      (sample),
		.left_in     (left_in),
		.right_in    (right_in),
		.tap_addr    (tap_addr),
		.tap_coeff   (tap_coeff),
		.hist_we     (hist_we),
		.left_addr   (left_addr),
		.right_addr  (right_addr),
		.left_wdata  (left_wdata),
		.right_wdata (right_wdata),
		.left_rdata  (left_rdata),
		.right_rdata (right_rdata),
		.left_out    (left_out),
		.right_out   (right_out),
		.sample_out  (sample_out)
	);

	sample_history i_hist_left (
		.clk   (clk),
		.we    (hist_we),
		.addr  (left_addr),
		.wdata (left_wdata),
		.rdata (left_rdata)
	);

	sample_history i_hist_right (
		.clk   (clk),
		.we    (hist_we),
		.addr  (right_addr),
		.wdata (right_wdata),
		.rdata (right_rdata)
	);

endmodule

// ==== hdl/sample_history.sv ====
`timescale 1ns/10ps

// One channel of sample history, addressed as a circular buffer by the core.
module sample_history
	import fir_pkg::*;
(
	input  logic       clk,
	input  logic       we,
	input  hist_addr_t addr,
	input  sample_t    wdata,
	output sample_t    rdata
);

	sample_t mem [2**HIST_ADDR_W];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	assign rdata = mem[addr]; // Asynchronous read, same address as the write.

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stereo FIR testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module fir_tb -f verilog.f -o fir_sim

status=0
./obj_dir/fir_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
	echo "Run reported a failure, see sim.log"
	exit 1
fi
exit 0

// ==== include/fir_ref_model.svh ====
`ifndef FIR_REF_MODEL_SVH
`define FIR_REF_MODEL_SVH

// Behavioural model of the stereo filter. Index 0 of each history is the newest sample.
fir_pkg::sample_t hist_l [fir_pkg::TAPS];
fir_pkg::sample_t hist_r [fir_pkg::TAPS];
fir_pkg::coeff_t  model_coeffs [fir_pkg::HALF_TAPS];

function automatic void reset_model();
	model_coeffs = fir_pkg::DEFAULT_COEFFS;
	foreach (hist_l[k]) begin
		hist_l[k] = '0;
		hist_r[k] = '0;
	end
endfunction

function automatic void set_model_coeff(int unsigned idx, fir_pkg::coeff_t value);
	if (idx < fir_pkg::HALF_TAPS)
		model_coeffs[idx] = value;
endfunction

function automatic void push_samples(fir_pkg::sample_t l, fir_pkg::sample_t r);
	for (int k = fir_pkg::TAPS - 1; k > 0; k--) begin
		hist_l[k] = hist_l[k-1];
		hist_r[k] = hist_r[k-1];
	end
	hist_l[0] = l;
	hist_r[0] = r;
endfunction

// Symmetric sum that wraps at the accumulator width.
function automatic fir_pkg::acc_t apply_filter(input fir_pkg::sample_t x [fir_pkg::TAPS]);
	fir_pkg::acc_t acc;
	acc = '0;
	for (int i = 0; i < fir_pkg::HALF_TAPS - 1; i++) begin
		acc = acc + fir_pkg::acc_t'(model_coeffs[i]) *
			(fir_pkg::acc_t'(x[i]) + fir_pkg::acc_t'(x[fir_pkg::TAPS - 1 - i]));
	end
	acc = acc + fir_pkg::acc_t'(model_coeffs[fir_pkg::HALF_TAPS - 1]) *
		fir_pkg::acc_t'(x[fir_pkg::HALF_TAPS - 1]);
	return acc;
endfunction

function automatic fir_pkg::acc_t expected_left();
	return apply_filter(hist_l);
endfunction

function automatic fir_pkg::acc_t expected_right();
	return apply_filter(hist_r);
endfunction

`endif

// ==== verification/fir_tb.sv ====
`timescale 1ns/10ps

module fir_tb
	import fir_pkg::*;
();

	localparam int LATENCY       = 76;
	localparam int STROBE_LIMIT  = 100;
	localparam int STROBE_COUNT  = 6 * TAPS + TAPS + 200 + 100 + 4 + 8;
	localparam longint WATCHDOG_NS = (longint'(STROBE_COUNT) * 80 + 5000) * 20;

	logic        clk;
	logic        rst;
	logic        sample;
	sample_t     left_in;
	sample_t     right_in;
	logic        coeff_we;
	coeff_addr_t coeff_waddr;
	coeff_t      coeff_wdata;
	coeff_addr_t coeff_raddr;
	coeff_t      coeff_rdata;
	acc_t        left_out;
	acc_t        right_out;
	logic        sample_out;

	coeff_t       cur_coeffs [HALF_TAPS];   // Table as last written.
	int           seed;
	int           error_count;
	int           tests_passed;
	int           tests_failed;

`include "fir_ref_model.svh"

	fir_top i_dut (
		.clk         (clk),
		.rst         (rst),
		.sample      (sample),
		.left_in     (left_in),
		.right_in    (right_in),
		.coeff_we    (coeff_we),
		.coeff_waddr (coeff_waddr),
		.coeff_wdata (coeff_wdata),
		.coeff_raddr (coeff_raddr),
		.coeff_rdata (coeff_rdata),
		.left_out    (left_out),
		.right_out   (right_out),
		.sample_out  (sample_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Ends a run that stops making progress.
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	task automatic check_acc(input string what, input acc_t got, input acc_t exp);
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_coeff(input string what, input coeff_t got, input coeff_t exp);
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_latency(input int got);
		if (got != LATENCY) begin
			error_count++;
			$display("MISMATCH at %0t: sample_out rose %0d edges after the strobe, expected %0d",
				$time, got, LATENCY);
		end
	endtask

	task automatic write_coeff(input int idx, input coeff_t value);
		@(negedge clk);
		coeff_we    = 1'b1;
		coeff_waddr = coeff_addr_t'(idx);
		coeff_wdata = value;
		@(negedge clk);
		coeff_we = 1'b0;
		cur_coeffs[idx] = value;
		set_model_coeff(idx, value);
	endtask

	task automatic read_coeff_check(input int idx, input coeff_t exp);
		@(negedge clk);
		coeff_raddr = coeff_addr_t'(idx);
		@(negedge clk); // The port is combinational and settled by now.
		check_coeff($sformatf("coeff[%0d]", idx), coeff_rdata, exp);
	endtask

	// One sample strobe; optionally a second edge while the core is busy.
	task automatic run_strobe(
		input  sample_t l,
		input  sample_t r,
		input  bit      check,
		input  bit      busy_strobe,
		output acc_t    got_l,
		output acc_t    got_r
	);
		acc_t exp_l;
		acc_t exp_r;
		int   edges;
		bit   seen;
		@(negedge clk);
		sample   = 1'b1;
		left_in  = l;
		right_in = r;
		push_samples(l, r);
		exp_l = expected_left();
		exp_r = expected_right();
		@(posedge clk);   // Edge where sample is first seen high.
		@(negedge clk);
		sample = 1'b0;
		edges  = 0;
		seen   = 1'b0;
		while (!seen && edges < STROBE_LIMIT) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			if (busy_strobe && edges == 30) begin
				sample   = 1'b1;
				left_in  = sample_t'($random(seed));
				right_in = sample_t'($random(seed));
			end else if (busy_strobe && edges == 31) begin
				sample = 1'b0;
			end
			if (sample_out) begin
				seen = 1'b1;
			end
		end
		got_l = left_out;
		got_r = right_out;
		if (!seen) begin
			error_count++;
			$display("Error at %0t: sample_out never rose within %0d cycles of the strobe",
				$time, STROBE_LIMIT);
		end else begin
			check_latency(edges);
			if (check) begin
				check_acc("left_out", got_l, exp_l);
				check_acc("right_out", got_r, exp_r);
			end
			@(negedge clk);
			if (sample_out) begin
				error_count++;
				$display("Error at %0t: sample_out stayed high for more than one cycle", $time);
			end
		end
	endtask

	// History in the DUT starts unknown, so results here go unchecked.
	task automatic flush_history();
		acc_t dummy_l;
		acc_t dummy_r;
		repeat (TAPS) run_strobe('0, '0, 1'b0, 1'b0, dummy_l, dummy_r);
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (sample_out) begin
				error_count++;
				$display("Error at %0t: extra sample_out pulse from a strobe while busy", $time);
			end
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (error_count == errs_before) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, error_count - errs_before);
		end
	endtask

	task automatic test_coeff_readback();
		coeff_t written [HALF_TAPS];
		int     errs;
		int     i;
		errs = error_count;
		flush_history();
		for (i = 0; i < HALF_TAPS; i++) read_coeff_check(i, DEFAULT_COEFFS[i]);
		for (i = 0; i < HALF_TAPS; i++) begin
			written[i] = coeff_t'($random(seed));
			write_coeff(i, written[i]);
		end
		for (i = 0; i < HALF_TAPS; i++) read_coeff_check(i, written[i]);
		for (i = 0; i < HALF_TAPS; i++) write_coeff(i, DEFAULT_COEFFS[i]); // Back to low-pass.
		finish_test("coefficient readback", errs);
	endtask

	task automatic test_impulse();
		acc_t got_l;
		acc_t got_r;
		int   errs;
		int   k;
		int   idx;
		errs = error_count;
		flush_history();
		for (k = 0; k < TAPS; k++) begin
			if (k == 0) begin
				run_strobe(sample_t'(1), sample_t'(-1), 1'b1, 1'b0, got_l, got_r);
			end else begin
				run_strobe('0, '0, 1'b1, 1'b0, got_l, got_r);
			end
			idx = (k < HALF_TAPS) ? k : TAPS - 1 - k; // Symmetric tap order.
			check_acc($sformatf("impulse left %0d", k), got_l, acc_t'(cur_coeffs[idx]));
			check_acc($sformatf("impulse right %0d", k), got_r, -acc_t'(cur_coeffs[idx]));
		end
		finish_test("impulse response", errs);
	endtask

	task automatic run_random_stream(input int count);
		acc_t    got_l;
		acc_t    got_r;
		sample_t l;
		sample_t r;
		int      n;
		for (n = 0; n < count; n++) begin
			if (n < 8) begin
				l = (n % 2) ? sample_t'(-256) : sample_t'(255); // Extremes first.
				r = (n % 2) ? sample_t'(255) : sample_t'(-256);
			end else begin
				l = sample_t'($random(seed));
				r = sample_t'($random(seed));
			end
			run_strobe(l, r, 1'b1, 1'b0, got_l, got_r);
		end
	endtask

	task automatic test_random_stream();
		int errs;
		errs = error_count;
		flush_history();
		run_random_stream(200);
		finish_test("random stereo stream", errs);
	endtask

	task automatic test_new_coeffs();
		int errs;
		int i;
		errs = error_count;
		flush_history();
		for (i = 0; i < HALF_TAPS; i++) write_coeff(i, coeff_t'($random(seed)));
		run_random_stream(100);
		finish_test("rewritten coefficients", errs);
	endtask

	task automatic test_busy_strobe();
		acc_t got_l;
		acc_t got_r;
		int   errs;
		errs = error_count;
		flush_history();
		run_strobe(sample_t'($random(seed)), sample_t'($random(seed)), 1'b1, 1'b1,
			got_l, got_r);
		expect_quiet(90);
		repeat (3) begin
			run_strobe(sample_t'($random(seed)), sample_t'($random(seed)), 1'b1, 1'b0,
				got_l, got_r);
		end
		finish_test("strobe while busy", errs);
	endtask

	// Latency and pulse width are checked on every strobe inside run_strobe.
	task automatic test_latency();
		int errs;
		errs = error_count;
		flush_history();
		run_random_stream(8);
		finish_test("latency", errs);
	endtask

	initial begin
		seed         = 70939;
		error_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		reset_model();
		cur_coeffs   = DEFAULT_COEFFS;
		rst          = 1'b1;
		sample       = 1'b0;
		left_in      = '0;
		right_in     = '0;
		coeff_we     = 1'b0;
		coeff_waddr  = '0;
		coeff_wdata  = '0;
		coeff_raddr  = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_coeff_readback();
		test_impulse();
		test_random_stream();
		test_new_coeffs();
		test_busy_strobe();
		test_latency();

		$display("Tests passed: %0d, failed: %0d, errors: %0d",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/fir_pkg.sv
hdl/sample_history.sv
hdl/coeff_regs.sv
hdl/fir_core.sv
hdl/fir_top.sv
verification/fir_tb.sv
